//--- vlog.f
verilog/beam_types_pkg.sv
verilog/beam_config_pkg.sv
verilog/beam_control.sv
verilog/complex_weighter.sv
verilog/channel_combiner.sv
verilog/beamformer_top.sv
bench/beamformer_assert.sv
bench/beamformer_checker.sv
bench/beamformer_tb.sv

//--- Makefile
# Verilator build and run of the beamformer testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = beamformer_tb
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the log
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/beamformer_tb.sv
// clock, reset, seeded random stimulus and test sequencing for the beamformer
`timescale 1ns/1ps

module beamformer_tb import beam_types_pkg::*, beam_config_pkg::*; ();

    localparam int LANES = 8;

    // cycles a beat may wait for s_ready, and cycles allowed to empty the pipeline
    localparam int ACCEPT_LIMIT = 64;
    localparam int DRAIN_LIMIT = 256;

    logic clock = 1'b0;
    logic resetn;

    logic [CHANNELS-1:0] s_valid;
    logic [CHANNELS-1:0] s_ready;
    sample_t [CHANNELS-1:0][LANES-1:0] s_data_re;
    sample_t [CHANNELS-1:0][LANES-1:0] s_data_im;
    weight_t [CHANNELS-1:0] s_weight_re;
    weight_t [CHANNELS-1:0] s_weight_im;
    logic s_last;

    logic m_valid;
    logic m_ready;
    sample_t [LANES-1:0] m_data_re;
    sample_t [LANES-1:0] m_data_im;
    logic m_last;

    // test sequencing shared with the scoreboard
    int test_id;
    logic test_done;
    logic report;
    int errors;
    int pending;

    bit timeout_hit;
    // when set the output side is throttled with a random m_ready every cycle
    bit random_ready;

    always #50 clock = ~clock;

    beamformer_top #(
        .LANES (LANES)
    ) UUT (
        .clock       (clock),
        .resetn      (resetn),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .s_data_re   (s_data_re),
        .s_data_im   (s_data_im),
        .s_weight_re (s_weight_re),
        .s_weight_im (s_weight_im),
        .s_last      (s_last),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_data_re   (m_data_re),
        .m_data_im   (m_data_im),
        .m_last      (m_last)
    );

    beamformer_checker #(
        .LANES (LANES)
    ) scoreboard (
        .clock       (clock),
        .resetn      (resetn),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .s_data_re   (s_data_re),
        .s_data_im   (s_data_im),
        .s_weight_re (s_weight_re),
        .s_weight_im (s_weight_im),
        .s_last      (s_last),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_data_re   (m_data_re),
        .m_data_im   (m_data_im),
        .m_last      (m_last),
        .test_id     (test_id),
        .test_done   (test_done),
        .report      (report),
        .errors      (errors),
        .pending     (pending)
    );

    // step to 1 ns past the next rising edge, where every input changes
    task automatic next_cycle();
        int unsigned r;
        @(posedge clock);
        #1;
        r = $urandom;
        m_ready = random_ready ? r[0] : 1'b1;
    endtask

    // random samples and weights on every channel and lane
    task automatic load_beat(input bit with_last);
        int unsigned r;
        for (int c = 0; c < CHANNELS; c++) begin
            for (int l = 0; l < LANES; l++) begin
                s_data_re[c][l] = sample_t'($urandom);
                s_data_im[c][l] = sample_t'($urandom);
            end
            s_weight_re[c] = weight_t'($urandom);
            s_weight_im[c] = weight_t'($urandom);
        end
        r = $urandom;
        s_last = with_last ? r[0] : 1'b0;
    endtask

    // raise all valids and hold the beat until the DUT takes it
    // s_ready is read at the falling edge, well away from the rising edge
    task automatic offer_beat(input string what);
        int cycles;
        bit taken;
        cycles = 0;
        taken = 1'b0;
        s_valid = '1;
        while (!taken && cycles < ACCEPT_LIMIT) begin
            @(negedge clock);
            taken = s_ready[0];
            next_cycle();
            cycles++;
        end
        s_valid = '0;
        if (!taken) begin
            $display("timeout: a %s beat was not accepted within %0d cycles", what, ACCEPT_LIMIT);
            timeout_hit = 1'b1;
        end
    endtask

    task automatic idle_cycles(input int n);
        s_valid = '0;
        repeat (n) next_cycle();
    endtask

    // wait until the scoreboard has seen every accepted beat come out
    task automatic wait_drain(input string what);
        int cycles;
        cycles = 0;
        while (pending != 0 && cycles < DRAIN_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (pending != 0) begin
            $display("timeout: %0d %s beats never left the pipeline", pending, what);
            timeout_hit = 1'b1;
        end
    endtask

    // one cycle of test_done lets the scoreboard close the running test
    task automatic end_test(input int next_id);
        test_done = 1'b1;
        next_cycle();
        test_done = 1'b0;
        test_id = next_id;
    endtask

    task automatic random_weights_test();
        for (int i = 0; i < 200 && !timeout_hit; i++) begin
            load_beat(1'b0);
            offer_beat("random_weights");
        end
        wait_drain("random_weights");
    endtask

    // full scale samples against a weight of minus one push the sum past both limits
    task automatic saturation_test();
        sample_t d_re;
        sample_t d_im;
        for (int k = 0; k < 4 && !timeout_hit; k++) begin
            case (k)
                0: begin
                    d_re = 16'sh8000;
                    d_im = 16'sh8000;
                end
                1: begin
                    d_re = 16'sh7fff;
                    d_im = 16'sh7fff;
                end
                2: begin
                    d_re = 16'sh8000;
                    d_im = 16'sh7fff;
                end
                default: begin
                    d_re = 16'sh7fff;
                    d_im = 16'sh8000;
                end
            endcase
            for (int c = 0; c < CHANNELS; c++) begin
                for (int l = 0; l < LANES; l++) begin
                    s_data_re[c][l] = d_re;
                    s_data_im[c][l] = d_im;
                end
                s_weight_re[c] = 8'sh80;
                s_weight_im[c] = 8'sh80;
            end
            s_last = 1'b0;
            offer_beat("saturation");
        end
        wait_drain("saturation");
    endtask

    task automatic back_pressure_test();
        random_ready = 1'b1;
        for (int i = 0; i < 150 && !timeout_hit; i++) begin
            idle_cycles($urandom % 3);
            load_beat(1'b0);
            offer_beat("back_pressure");
        end
        wait_drain("back_pressure");
        random_ready = 1'b0;
    endtask

    // each channel raises its valid after its own delay and keeps it up
    task automatic partial_valid_test();
        int delay [CHANNELS];
        int top_delay;
        for (int i = 0; i < 100 && !timeout_hit; i++) begin
            load_beat(1'b0);
            top_delay = 0;
            for (int c = 0; c < CHANNELS; c++) begin
                delay[c] = $urandom % 4;
                if (delay[c] > top_delay) begin
                    top_delay = delay[c];
                end
            end
            for (int k = 0; k < top_delay; k++) begin
                for (int c = 0; c < CHANNELS; c++) begin
                    s_valid[c] = (delay[c] <= k);
                end
                next_cycle();
            end
            offer_beat("partial_valid");
        end
        wait_drain("partial_valid");
    endtask

    task automatic last_forwarding_test();
        for (int i = 0; i < 120 && !timeout_hit; i++) begin
            idle_cycles($urandom % 2);
            load_beat(1'b1);
            offer_beat("last_forwarding");
        end
        wait_drain("last_forwarding");
    endtask

    initial begin
        void'($urandom(32'h942));
        resetn = 1'b0;
        s_valid = '0;
        s_data_re = '0;
        s_data_im = '0;
        s_weight_re = '0;
        s_weight_im = '0;
        s_last = 1'b0;
        m_ready = 1'b1;
        test_id = 0;
        test_done = 1'b0;
        report = 1'b0;
        timeout_hit = 1'b0;
        random_ready = 1'b0;

        repeat (4) @(posedge clock);
        #1;
        resetn = 1'b1;
        // the DUT keeps its input closed for this one cycle
        next_cycle();
        end_test(1);

        if (!timeout_hit) random_weights_test();
        end_test(2);
        if (!timeout_hit) saturation_test();
        end_test(3);
        if (!timeout_hit) back_pressure_test();
        end_test(4);
        if (!timeout_hit) partial_valid_test();
        end_test(5);
        if (!timeout_hit) last_forwarding_test();
        end_test(6);

        report = 1'b1;
        next_cycle();
        report = 1'b0;
        next_cycle();

        if (timeout_hit || errors != 0) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

endmodule

//--- bench/beamformer_checker.sv
// reference model, scoreboard queue and per-test reporting for the beamformer
`timescale 1ns/1ps

module beamformer_checker import beam_types_pkg::*, beam_config_pkg::*; #(
    parameter int LANES = 8
) (
    input  logic                              clock,
    input  logic                              resetn,
    input  logic    [CHANNELS-1:0]            s_valid,
    input  logic    [CHANNELS-1:0]            s_ready,
    input  sample_t [CHANNELS-1:0][LANES-1:0] s_data_re,
    input  sample_t [CHANNELS-1:0][LANES-1:0] s_data_im,
    input  weight_t [CHANNELS-1:0]            s_weight_re,
    input  weight_t [CHANNELS-1:0]            s_weight_im,
    input  logic                              s_last,
    input  logic                              m_valid,
    input  logic                              m_ready,
    input  sample_t [LANES-1:0]               m_data_re,
    input  sample_t [LANES-1:0]               m_data_im,
    input  logic                              m_last,
    input  int                                test_id,
    input  logic                              test_done,
    input  logic                              report,
    output int                                errors,
    output int                                pending
);

    typedef logic [LANES*16-1:0] lanes_t;

    // expected beats in acceptance order, with the cycle and stall count at acceptance
    lanes_t exp_re_q [$];
    lanes_t exp_im_q [$];
    logic exp_last_q [$];
    int exp_cycle_q [$];
    int exp_stall_q [$];

    int cycle = 0;
    int stalls = 0;
    logic prev_resetn = 1'b0;
    int error_total = 0;
    int checked_total = 0;
    int tests_done = 0;
    int test_errors = 0;
    int test_accepts = 0;
    int test_outputs = 0;
    int pending_count = 0;

    assign errors = error_total;
    assign pending = pending_count;

    function automatic string test_name(input int id);
        case (id)
            0: return "reset_quiet";
            1: return "random_weights";
            2: return "saturation";
            3: return "back_pressure";
            4: return "partial_valid";
            5: return "last_forwarding";
            default: return "unknown";
        endcase
    endfunction

    function automatic sample_t clamp_sample(input longint value);
        if (value > SAMPLE_MAX) return 16'sh7fff;
        if (value < SAMPLE_MIN) return 16'sh8000;
        return sample_t'(value);
    endfunction

    // full precision complex weighting and channel sum in 64-bit integers
    // then a floor shift by the fraction bits plus two and a clamp to 16 bits
    function automatic void model_beat(output lanes_t re, output lanes_t im);
        longint acc_re;
        longint acc_im;
        longint dr;
        longint di;
        longint wr;
        longint wi;
        for (int l = 0; l < LANES; l++) begin
            acc_re = 0;
            acc_im = 0;
            for (int c = 0; c < CHANNELS; c++) begin
                dr = $signed(s_data_re[c][l]);
                di = $signed(s_data_im[c][l]);
                wr = $signed(s_weight_re[c]);
                wi = $signed(s_weight_im[c]);
                acc_re = acc_re + dr * wr - di * wi;
                acc_im = acc_im + dr * wi + di * wr;
            end
            re[l*16 +: 16] = clamp_sample(acc_re >>> SUM_SHIFT);
            im[l*16 +: 16] = clamp_sample(acc_im >>> SUM_SHIFT);
        end
    endfunction

    function automatic void mismatch_data(input string what, input lanes_t exp, input lanes_t act);
        $display("CHECK FAILED %s %s expected %h actual %h", test_name(test_id), what, exp, act);
        error_total++;
        test_errors++;
    endfunction

    function automatic void mismatch_int(input string what, input int exp, input int act);
        $display("CHECK FAILED %s %s expected %0d actual %0d", test_name(test_id), what, exp, act);
        error_total++;
        test_errors++;
    endfunction

    // everything is sampled at the falling edge where inputs and outputs are settled
    always @(negedge clock) begin
        lanes_t exp_re;
        lanes_t exp_im;
        logic exp_last;
        int latency;
        int stall_gap;
        cycle++;
        // a stalled cycle freezes the whole pipeline for one clock
        if (m_valid && !m_ready) stalls++;

        // during reset and the hold cycle after it nothing may move
        if (!resetn || !prev_resetn) begin
            if (m_valid !== 1'b0) mismatch_int("m_valid in reset", 0, int'(m_valid));
            if (s_ready !== '0) mismatch_int("s_ready in reset", 0, int'(s_ready));
        end
        prev_resetn = resetn;

        if (resetn && s_ready[0] && (&s_valid)) begin
            model_beat(exp_re, exp_im);
            exp_re_q.push_back(exp_re);
            exp_im_q.push_back(exp_im);
            exp_last_q.push_back(s_last);
            exp_cycle_q.push_back(cycle);
            exp_stall_q.push_back(stalls);
            test_accepts++;
        end

        if (resetn && m_valid && m_ready) begin
            test_outputs++;
            checked_total++;
            if (exp_re_q.size() == 0) begin
                $display("ERROR: %s an output beat arrived with no beat pending",
                         test_name(test_id));
                error_total++;
                test_errors++;
            end else begin
                exp_re = exp_re_q.pop_front();
                exp_im = exp_im_q.pop_front();
                exp_last = exp_last_q.pop_front();
                latency = cycle - exp_cycle_q.pop_front();
                stall_gap = stalls - exp_stall_q.pop_front();
                if (m_data_re !== exp_re) mismatch_data("m_data_re", exp_re, m_data_re);
                if (m_data_im !== exp_im) mismatch_data("m_data_im", exp_im, m_data_im);
                if (m_last !== exp_last) mismatch_int("m_last", int'(exp_last), int'(m_last));
                // four stages plus every cycle the pipeline stood still
                if (latency != PIPE_DEPTH + stall_gap) begin
                    mismatch_int("latency", PIPE_DEPTH + stall_gap, latency);
                end
            end
        end
        pending_count = exp_re_q.size();

        if (test_done) begin
            if (test_outputs != test_accepts) begin
                mismatch_int("output count", test_accepts, test_outputs);
            end
            if (pending_count != 0) begin
                $display("ERROR: %s ended with %0d beats still in the pipeline",
                         test_name(test_id), pending_count);
                error_total++;
                test_errors++;
            end
            $display("test %s finished: %0d beats checked, %0d errors",
                     test_name(test_id), test_outputs, test_errors);
            tests_done++;
            test_errors = 0;
            test_accepts = 0;
            test_outputs = 0;
        end

        if (report) begin
            $display("summary: %0d tests, %0d beats checked, %0d errors",
                     tests_done, checked_total, error_total);
        end
    end

endmodule

//--- bench/beamformer_assert.sv
// concurrent handshake assertions bound into the beamformer top level
`timescale 1ns/1ps

module beamformer_assert import beam_types_pkg::*, beam_config_pkg::*; #(
    parameter int LANES = 8
) (
    input logic                clock,
    input logic                resetn,
    input logic [CHANNELS-1:0] s_ready,
    input logic                m_valid,
    input logic                m_ready,
    input sample_t [LANES-1:0] m_data_re,
    input sample_t [LANES-1:0] m_data_im,
    input logic                m_last
);

    // a reset edge clears the output stage
    output_idle_in_reset: assert property (@(posedge clock) !resetn |=> !m_valid)
        else $error("m_valid was high on the cycle after a reset edge");

    // a stalled beat keeps its valid, data and tlast until it is taken
    output_held_on_stall: assert property (@(posedge clock) disable iff (!resetn)
        m_valid && !m_ready |=> m_valid && $stable(m_data_re) && $stable(m_data_im)
            && $stable(m_last))
        else $error("output beat changed while m_ready was low");

    // once running every channel shows the same ready
    // and it is low exactly while a finished beat waits on the output
    ready_shared: assert property (@(posedge clock) disable iff (!resetn)
        $past(resetn) |-> s_ready == {CHANNELS{!m_valid || m_ready}})
        else $error("s_ready differs between channels or ignores the output stall");

endmodule

bind beamformer_top beamformer_assert #(
    .LANES (LANES)
) u_assert (
    .clock     (clock),
    .resetn    (resetn),
    .s_ready   (s_ready),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_data_re (m_data_re),
    .m_data_im (m_data_im),
    .m_last    (m_last)
);

//--- verilog/beamformer_top.sv
// four-channel receive beamformer with one merged output stream
`timescale 1ns/1ps

module beamformer_top import beam_types_pkg::*, beam_config_pkg::*; #(
    parameter int LANES = 8
) (
    input  logic                              clock,
    input  logic                              resetn,

    // input streams with one handshake per channel
    input  logic     [CHANNELS-1:0]           s_valid,
    output logic     [CHANNELS-1:0]           s_ready,
    input  sample_t  [CHANNELS-1:0][LANES-1:0] s_data_re,
    input  sample_t  [CHANNELS-1:0][LANES-1:0] s_data_im,
    input  weight_t  [CHANNELS-1:0]           s_weight_re,
    input  weight_t  [CHANNELS-1:0]           s_weight_im,

    // only channel 0 carries a tlast
    input  logic                              s_last,

    // beamformed output stream
    output logic                              m_valid,
    input  logic                              m_ready,
    output sample_t  [LANES-1:0]              m_data_re,
    output sample_t  [LANES-1:0]              m_data_im,
    output logic                              m_last
);

    // one stage enable shared by every register of the datapath
    logic advance;

    // weighted lanes of every channel on their way to the combiner
    product_t [CHANNELS-1:0][LANES-1:0] prod_re;
    product_t [CHANNELS-1:0][LANES-1:0] prod_im;

    // handshake and the valid and tlast shift registers
    // the datapath itself carries no valid bits
    beam_control u_control (
        .clock   (clock),
        .resetn  (resetn),
        .s_valid (s_valid),
        .s_last  (s_last),
        .m_ready (m_ready),
        .s_ready (s_ready),
        .advance (advance),
        .m_valid (m_valid),
        .m_last  (m_last)
    );

    // one weighter per channel
    // each sees only its own samples and its own weight
    for (genvar c = 0; c < CHANNELS; c++) begin : g_channel
        complex_weighter #(
            .LANES (LANES)
        ) u_weighter (
            .clock     (clock),
            .advance   (advance),
            .data_re   (s_data_re[c]),
            .data_im   (s_data_im[c]),
            .weight_re (s_weight_re[c]),
            .weight_im (s_weight_im[c]),
            .prod_re   (prod_re[c]),
            .prod_im   (prod_im[c])
        );
    end

    // the combiner output registers drive the output data directly
    // so data lines up with m_valid from the control shift register
    channel_combiner #(
        .LANES (LANES)
    ) u_combiner (
        .clock   (clock),
        .advance (advance),
        .prod_re (prod_re),
        .prod_im (prod_im),
        .out_re  (m_data_re),
        .out_im  (m_data_im)
    );

endmodule

//--- verilog/channel_combiner.sv
// lane-wise sum of all channels with scaling and saturation in two stages
`timescale 1ns/1ps

module channel_combiner import beam_types_pkg::*, beam_config_pkg::*; #(
    parameter int LANES = 8
) (
    input  logic                               clock,
    input  logic                               advance,
    input  product_t [CHANNELS-1:0][LANES-1:0] prod_re,
    input  product_t [CHANNELS-1:0][LANES-1:0] prod_im,
    output sample_t  [LANES-1:0]               out_re,
    output sample_t  [LANES-1:0]               out_im
);

    // combinational lane sums ahead of the stage one register
    sum_t lane_re [LANES];
    sum_t lane_im [LANES];

    // stage one register
    sum_t sum_re [LANES];
    sum_t sum_im [LANES];

    // scale a lane sum back to sample range and clamp it
    // the arithmetic shift rounds toward minus infinity
    // it also removes the weight fraction and divides by the channel count
    function automatic sample_t scale_saturate(input sum_t value);
        sum_t scaled;
        scaled = value >>> SUM_SHIFT;
        if (scaled > SAMPLE_MAX) begin
            return sample_t'(SAMPLE_MAX);
        end
        if (scaled < SAMPLE_MIN) begin
            return sample_t'(SAMPLE_MIN);
        end
        return sample_t'(scaled);
    endfunction

    // add the same lane of every channel
    // each product is sign extended to the sum width before the add
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            lane_re[l] = '0;
            lane_im[l] = '0;
            for (int c = 0; c < CHANNELS; c++) begin
                lane_re[l] = lane_re[l] + $signed(prod_re[c][l]);
                lane_im[l] = lane_im[l] + $signed(prod_im[c][l]);
            end
        end
    end

    // stage one keeps the full width sum
    always_ff @(posedge clock) begin
        if (advance) begin
            for (int l = 0; l < LANES; l++) begin
                sum_re[l] <= lane_re[l];
                sum_im[l] <= lane_im[l];
            end
        end
    end

    // stage two is the output data register of the stream
    // it holds still while the output is stalled
    always_ff @(posedge clock) begin
        if (advance) begin
            for (int l = 0; l < LANES; l++) begin
                out_re[l] <= scale_saturate(sum_re[l]);
                out_im[l] <= scale_saturate(sum_im[l]);
            end
        end
    end

endmodule

//--- verilog/complex_weighter.sv
// per-channel complex multiply of every lane by the channel weight in two stages
`timescale 1ns/1ps

module complex_weighter import beam_types_pkg::*; #(
    parameter int LANES = 8
) (
    input  logic                 clock,
    input  logic                 advance,
    input  sample_t  [LANES-1:0] data_re,
    input  sample_t  [LANES-1:0] data_im,
    input  weight_t              weight_re,
    input  weight_t              weight_im,
    output product_t [LANES-1:0] prod_re,
    output product_t [LANES-1:0] prod_im
);

    // stage one holds the four partial products of every lane
    // the names give the sample part first and the weight part second
    product_t pp_rr [LANES];
    product_t pp_ii [LANES];
    product_t pp_ri [LANES];
    product_t pp_ir [LANES];

    // stage one
    // the weight is taken on the same edge as the beat it belongs to
    // so a new weight can come with every accepted beat
    // every product is kept at full precision with no rounding here
    always_ff @(posedge clock) begin
        if (advance) begin
            for (int l = 0; l < LANES; l++) begin
                // real sample times real weight
                pp_rr[l] <= $signed(data_re[l]) * weight_re;
                // imaginary sample times imaginary weight
                pp_ii[l] <= $signed(data_im[l]) * weight_im;
                // real sample times imaginary weight
                pp_ri[l] <= $signed(data_re[l]) * weight_im;
                // imaginary sample times real weight
                pp_ir[l] <= $signed(data_im[l]) * weight_re;
            end
        end
    end

    // stage two
    // (a + jb)(c + jd) gives ac - bd for the real part
    // and ad + bc for the imaginary part
    // the 25-bit result cannot wrap even for two full scale products
    always_ff @(posedge clock) begin
        if (advance) begin
            for (int l = 0; l < LANES; l++) begin
                prod_re[l] <= pp_rr[l] - pp_ii[l];
                prod_im[l] <= pp_ri[l] + pp_ir[l];
            end
        end
    end

    // both stages share the one enable so lanes never slip
    // against each other or against the control pipeline

endmodule

//--- verilog/beam_control.sv
// handshake, stall and valid/tlast pipeline control of the beamformer
`timescale 1ns/1ps

module beam_control import beam_types_pkg::*, beam_config_pkg::*; (
    input  logic                clock,
    input  logic                resetn,
    input  logic [CHANNELS-1:0] s_valid,
    input  logic                s_last,
    input  logic                m_ready,
    output logic [CHANNELS-1:0] s_ready,
    output logic                advance,
    output logic                m_valid,
    output logic                m_last
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    // one flag per registered stage of the datapath
    logic [PIPE_DEPTH-1:0] valid_pipe;
    logic [PIPE_DEPTH-1:0] last_pipe;

    logic ready;
    logic accept;

    // leave RESET_HOLD after one cycle and never come back without a reset
    always_comb begin
        state_next = state;
        case (state)
            RESET_HOLD: state_next = RUNNING;
            RUNNING:    state_next = RUNNING;
            default:    state_next = RESET_HOLD;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= RESET_HOLD;
        end else begin
            state <= state_next;
        end
    end

    // the whole pipeline moves unless a finished beat is waiting on the output
    assign advance = !valid_pipe[PIPE_DEPTH-1] || m_ready;

    // ready does not look at any s_valid so sources cannot form a loop through it
    assign ready = advance && (state == RUNNING);
    assign s_ready = {CHANNELS{ready}};

    // all four channels are consumed together on the same edge
    assign accept = ready && (&s_valid);

    // the accept flag and channel 0 tlast walk along with the beat
    // a bubble carries a low tlast so m_last is only seen with m_valid
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else if (advance) begin
            valid_pipe <= {valid_pipe[PIPE_DEPTH-2:0], accept};
            last_pipe  <= {last_pipe[PIPE_DEPTH-2:0], accept && s_last};
        end
    end

    // the last stage is the output register of the stream
    assign m_valid = valid_pipe[PIPE_DEPTH-1];
    assign m_last  = last_pipe[PIPE_DEPTH-1];

endmodule

//--- verilog/beam_config_pkg.sv
// channel count, weight scaling, pipeline depth and output clamp limits
package beam_config_pkg;

    // number of input channels combined into the one output beam
    // the output scaling below relies on this being a power of two
    localparam int CHANNELS = 4;

    // fraction bits of every weight part
    localparam int WEIGHT_FRAC = 7;

    // removing the weight fraction and dividing by the channel count
    // is a single arithmetic right shift of the lane sum
    localparam int SUM_SHIFT = WEIGHT_FRAC + $clog2(CHANNELS);

    // two weighter stages followed by two combiner stages
    localparam int PIPE_DEPTH = 4;

    // clamp limits of a 16-bit output sample part
    localparam int SAMPLE_MAX = 32767;
    localparam int SAMPLE_MIN = -32768;

endpackage

//--- verilog/beam_types_pkg.sv
// sample, weight, product and sum types plus the control state encoding
package beam_types_pkg;

    // one real or imaginary part of an input or output sample
    typedef logic signed [15:0] sample_t;

    // one part of a channel weight with 7 fraction bits
    // so 8'sd64 stands for one half and 8'sh80 for minus one
    typedef logic signed [7:0] weight_t;

    // a 16 by 8 signed product needs 24 bits
    // the sum or difference of two such products needs one more
    typedef logic signed [24:0] product_t;

    // adding four weighted channels grows the word by two more bits
    // so the worst case of four full scale products still fits
    typedef logic signed [26:0] sum_t;

    // the control FSM keeps the input closed for one cycle after reset
    // and then stays in RUNNING until the next reset
    typedef enum logic [0:0] {
        RESET_HOLD,
        RUNNING
    } ctrl_state_t;

endpackage
